/* include/axi_sram_macros.svh */
`ifndef AXI_SRAM_MACROS_SVH
`define AXI_SRAM_MACROS_SVH

// AXI side widths
`define AXI_ADDR_W 12
`define AXI_DATA_W 32
`define AXI_ID_W   4
`define AXI_STRB_W (`AXI_DATA_W / 8)

// Word addressing on the SRAM side
`define SRAM_LSB    2
`define SRAM_ADDR_W (`AXI_ADDR_W - `SRAM_LSB)

`endif

/* logic/axi_sram_pkg.sv */
`include "axi_sram_macros.svh"

package axi_sram_pkg;

  localparam logic [1:0] resp_okay = 2'b00;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } axi_aw_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } axi_ar_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic [1:0]           resp;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } axi_r_t;

  // Meta carries the AXI id through the memory
  typedef struct packed {
    logic                    wr_en;
    logic [`SRAM_ADDR_W-1:0] addr;
    logic [`AXI_ID_W-1:0]    meta;
    logic                    last;
    logic [`AXI_DATA_W-1:0]  wr_data;
    logic [`AXI_STRB_W-1:0]  wr_strb;
  } sram_cmd_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   meta;
    logic                   last;
    logic [`AXI_DATA_W-1:0] rd_data;
  } sram_resp_t;

endpackage

/* logic/axi_sram_wr.sv */
`timescale 1ns/100ps
`include "axi_sram_macros.svh"

module axi_sram_wr (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_aw_valid,
  output logic                    o_aw_ready,
  input  axi_sram_pkg::axi_aw_t   i_aw,
  input  logic                    i_w_valid,
  output logic                    o_w_ready,
  input  axi_sram_pkg::axi_w_t    i_w,
  output logic                    o_b_valid,
  input  logic                    i_b_ready,
  output axi_sram_pkg::axi_b_t    o_b,
  output logic                    o_cmd_valid,
  input  logic                    i_cmd_ready,
  output logic [`SRAM_ADDR_W-1:0] o_cmd_addr,
  output logic [`AXI_DATA_W-1:0]  o_cmd_data,
  output logic [`AXI_STRB_W-1:0]  o_cmd_strb
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_t;

  wr_state_t               state;
  logic                    ready_en;
  logic [`AXI_ID_W-1:0]    id_q;
  logic [`SRAM_ADDR_W-1:0] addr_q;

  // AW ready stays low through reset and the first cycle after it
  assign o_aw_ready = (state == wr_idle) && ready_en;

  // Beats go straight through, so W ready follows the SRAM port
  assign o_cmd_valid = (state == wr_data) && i_w_valid;
  assign o_w_ready   = (state == wr_data) && i_cmd_ready;
  assign o_cmd_addr  = addr_q;
  assign o_cmd_data  = i_w.data;
  assign o_cmd_strb  = i_w.strb;

  assign o_b_valid = (state == wr_resp);
  assign o_b.id    = id_q;
  assign o_b.resp  = resp_okay;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= wr_idle;
      ready_en <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      case (state)
        wr_idle: begin
          if (i_aw_valid && o_aw_ready) begin
            state <= wr_data;
          end
        end
        wr_data: begin
          if (i_w_valid && o_w_ready && i_w.last) begin
            state <= wr_resp;
          end
        end
        default: begin
          if (i_b_ready) begin
            state <= wr_idle;
          end
        end
      endcase
    end
  end

  // Burst id and word address
  always_ff @(posedge clk) begin
    if (i_aw_valid && o_aw_ready) begin
      id_q   <= i_aw.id;
      addr_q <= i_aw.addr[`AXI_ADDR_W-1:`SRAM_LSB];
    end else if (i_w_valid && o_w_ready) begin
      addr_q <= addr_q + 1'b1;
    end
  end

endmodule

/* logic/axi_sram_rd.sv */
`timescale 1ns/100ps
`include "axi_sram_macros.svh"

module axi_sram_rd (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_ar_valid,
  output logic                    o_ar_ready,
  input  axi_sram_pkg::axi_ar_t   i_ar,
  output logic                    o_r_valid,
  input  logic                    i_r_ready,
  output axi_sram_pkg::axi_r_t    o_r,
  output logic                    o_cmd_valid,
  input  logic                    i_cmd_ready,
  output logic [`SRAM_ADDR_W-1:0] o_cmd_addr,
  output logic [`AXI_ID_W-1:0]    o_cmd_meta,
  output logic                    o_cmd_last,
  input  logic                    i_resp_valid,
  output logic                    o_resp_ready,
  input  axi_sram_pkg::sram_resp_t i_resp
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    rd_idle,
    rd_cmd,
    rd_wait
  } rd_state_t;

  rd_state_t               state;
  logic                    ready_en;
  logic [`AXI_ID_W-1:0]    id_q;
  logic [`SRAM_ADDR_W-1:0] addr_q;
  logic [7:0]              cnt_q;
  logic                    cmd_fire;

  // AR ready stays low through reset and the first cycle after it
  assign o_ar_ready = (state == rd_idle) && ready_en;

  assign o_cmd_valid = (state == rd_cmd);
  assign o_cmd_addr  = addr_q;
  assign o_cmd_meta  = id_q;
  assign o_cmd_last  = (cnt_q == 8'd0);
  assign cmd_fire    = o_cmd_valid && i_cmd_ready;

  // R is the SRAM response with an OKAY attached
  assign o_r_valid    = i_resp_valid;
  assign o_r.id       = i_resp.meta;
  assign o_r.data     = i_resp.rd_data;
  assign o_r.resp     = resp_okay;
  assign o_r.last     = i_resp.last;
  assign o_resp_ready = i_r_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= rd_idle;
      ready_en <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      case (state)
        rd_idle: begin
          if (i_ar_valid && o_ar_ready) begin
            state <= rd_cmd;
          end
        end
        rd_cmd: begin
          if (cmd_fire && o_cmd_last) begin
            state <= rd_wait;
          end
        end
        default: begin
          if (o_r_valid && i_r_ready && o_r.last) begin
            state <= rd_idle;
          end
        end
      endcase
    end
  end

  // Remaining beats count down to zero
  always_ff @(posedge clk) begin
    if (i_ar_valid && o_ar_ready) begin
      id_q   <= i_ar.id;
      addr_q <= i_ar.addr[`AXI_ADDR_W-1:`SRAM_LSB];
      cnt_q  <= i_ar.len;
    end else if (cmd_fire) begin
      addr_q <= addr_q + 1'b1;
      cnt_q  <= cnt_q - 1'b1;
    end
  end

endmodule

/* logic/axi_sram_bridge.sv */
`timescale 1ns/100ps
`include "axi_sram_macros.svh"

module axi_sram_bridge (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_aw_valid,
  output logic                      o_aw_ready,
  input  axi_sram_pkg::axi_aw_t     i_aw,
  input  logic                      i_w_valid,
  output logic                      o_w_ready,
  input  axi_sram_pkg::axi_w_t      i_w,
  output logic                      o_b_valid,
  input  logic                      i_b_ready,
  output axi_sram_pkg::axi_b_t      o_b,
  input  logic                      i_ar_valid,
  output logic                      o_ar_ready,
  input  axi_sram_pkg::axi_ar_t     i_ar,
  output logic                      o_r_valid,
  input  logic                      i_r_ready,
  output axi_sram_pkg::axi_r_t      o_r,
  output logic                      o_cmd_valid,
  input  logic                      i_cmd_ready,
  output axi_sram_pkg::sram_cmd_t   o_cmd,
  input  logic                      i_resp_valid,
  output logic                      o_resp_ready,
  input  axi_sram_pkg::sram_resp_t  i_resp
);
  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write
  } arb_state_t;

  arb_state_t              state;
  arb_state_t              state_next;
  logic                    wr_cmd_valid;
  logic                    wr_cmd_ready;
  logic [`SRAM_ADDR_W-1:0] wr_cmd_addr;
  logic [`AXI_DATA_W-1:0]  wr_cmd_data;
  logic [`AXI_STRB_W-1:0]  wr_cmd_strb;
  logic                    rd_cmd_valid;
  logic                    rd_cmd_ready;
  logic [`SRAM_ADDR_W-1:0] rd_cmd_addr;
  logic [`AXI_ID_W-1:0]    rd_cmd_meta;
  logic                    rd_cmd_last;

  axi_sram_wr u_wr (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_aw_valid  (i_aw_valid),
    .o_aw_ready  (o_aw_ready),
    .i_aw        (i_aw),
    .i_w_valid   (i_w_valid),
    .o_w_ready   (o_w_ready),
    .i_w         (i_w),
    .o_b_valid   (o_b_valid),
    .i_b_ready   (i_b_ready),
    .o_b         (o_b),
    .o_cmd_valid (wr_cmd_valid),
    .i_cmd_ready (wr_cmd_ready),
    .o_cmd_addr  (wr_cmd_addr),
    .o_cmd_data  (wr_cmd_data),
    .o_cmd_strb  (wr_cmd_strb)
  );

  axi_sram_rd u_rd (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_ar_valid   (i_ar_valid),
    .o_ar_ready   (o_ar_ready),
    .i_ar         (i_ar),
    .o_r_valid    (o_r_valid),
    .i_r_ready    (i_r_ready),
    .o_r          (o_r),
    .o_cmd_valid  (rd_cmd_valid),
    .i_cmd_ready  (rd_cmd_ready),
    .o_cmd_addr   (rd_cmd_addr),
    .o_cmd_meta   (rd_cmd_meta),
    .o_cmd_last   (rd_cmd_last),
    .i_resp_valid (i_resp_valid),
    .o_resp_ready (o_resp_ready),
    .i_resp       (i_resp)
  );

  // A finished burst hands the next turn to the other direction
  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (rd_cmd_valid) begin
          state_next = st_read;
        end else if (wr_cmd_valid) begin
          state_next = st_write;
        end
      end
      st_read: begin
        if (i_resp_valid && o_resp_ready && i_resp.last) begin
          if (wr_cmd_valid) begin
            state_next = st_write;
          end else if (rd_cmd_valid) begin
            state_next = st_read;
          end else begin
            state_next = st_idle;
          end
        end
      end
      default: begin
        if (o_b_valid && i_b_ready) begin
          if (rd_cmd_valid) begin
            state_next = st_read;
          end else if (wr_cmd_valid) begin
            state_next = st_write;
          end else begin
            state_next = st_idle;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Command steering follows the next state
  always_comb begin
    o_cmd_valid   = 1'b0;
    o_cmd.wr_en   = 1'b0;
    o_cmd.addr    = '0;
    o_cmd.meta    = '0;
    o_cmd.last    = 1'b0;
    o_cmd.wr_data = '0;
    o_cmd.wr_strb = '0;
    rd_cmd_ready  = 1'b0;
    wr_cmd_ready  = 1'b0;
    case (state_next)
      st_read: begin
        o_cmd_valid  = rd_cmd_valid;
        o_cmd.addr   = rd_cmd_addr;
        o_cmd.meta   = rd_cmd_meta;
        o_cmd.last   = rd_cmd_last;
        rd_cmd_ready = i_cmd_ready;
      end
      st_write: begin
        o_cmd_valid   = wr_cmd_valid;
        o_cmd.wr_en   = 1'b1;
        o_cmd.addr    = wr_cmd_addr;
        o_cmd.wr_data = wr_cmd_data;
        o_cmd.wr_strb = wr_cmd_strb;
        wr_cmd_ready  = i_cmd_ready;
      end
      default: begin
        o_cmd_valid = 1'b0;
      end
    endcase
  end

endmodule

/* logic/sram_store.sv */
`timescale 1ns/100ps
`include "axi_sram_macros.svh"

module sram_store (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_cmd_valid,
  output logic                     o_cmd_ready,
  input  axi_sram_pkg::sram_cmd_t  i_cmd,
  output logic                     o_resp_valid,
  input  logic                     i_resp_ready,
  output axi_sram_pkg::sram_resp_t o_resp
);
  localparam int mem_depth = 2 ** `SRAM_ADDR_W;

  logic [`AXI_DATA_W-1:0] mem [mem_depth];
  logic                   cmd_fire;
  logic                   rd_fire;

  // Stall while a response waits to be taken
  assign o_cmd_ready = !o_resp_valid || i_resp_ready;
  assign cmd_fire    = i_cmd_valid && o_cmd_ready;
  assign rd_fire     = cmd_fire && !i_cmd.wr_en;

  always_ff @(posedge clk) begin
    if (cmd_fire && i_cmd.wr_en) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (i_cmd.wr_strb[b]) begin
          mem[i_cmd.addr][b*8 +: 8] <= i_cmd.wr_data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_resp_valid <= 1'b0;
    end else if (rd_fire) begin
      o_resp_valid <= 1'b1;
    end else if (i_resp_ready) begin
      o_resp_valid <= 1'b0;
    end
  end

  // One-entry response register
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      o_resp.meta    <= i_cmd.meta;
      o_resp.last    <= i_cmd.last;
      o_resp.rd_data <= mem[i_cmd.addr];
    end
  end

endmodule

/* logic/axi_sram_top.sv */
`timescale 1ns/100ps

module axi_sram_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_aw_valid,
  output logic                  o_aw_ready,
  input  axi_sram_pkg::axi_aw_t i_aw,
  input  logic                  i_w_valid,
  output logic                  o_w_ready,
  input  axi_sram_pkg::axi_w_t  i_w,
  output logic                  o_b_valid,
  input  logic                  i_b_ready,
  output axi_sram_pkg::axi_b_t  o_b,
  input  logic                  i_ar_valid,
  output logic                  o_ar_ready,
  input  axi_sram_pkg::axi_ar_t i_ar,
  output logic                  o_r_valid,
  input  logic                  i_r_ready,
  output axi_sram_pkg::axi_r_t  o_r
);
  import axi_sram_pkg::*;

  logic       cmd_valid;
  logic       cmd_ready;
  sram_cmd_t  cmd;
  logic       resp_valid;
  logic       resp_ready;
  sram_resp_t resp;

  axi_sram_bridge u_bridge (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_aw_valid   (i_aw_valid),
    .o_aw_ready   (o_aw_ready),
    .i_aw         (i_aw),
    .i_w_valid    (i_w_valid),
    .o_w_ready    (o_w_ready),
    .i_w          (i_w),
    .o_b_valid    (o_b_valid),
    .i_b_ready    (i_b_ready),
    .o_b          (o_b),
    .i_ar_valid   (i_ar_valid),
    .o_ar_ready   (o_ar_ready),
    .i_ar         (i_ar),
    .o_r_valid    (o_r_valid),
    .i_r_ready    (i_r_ready),
    .o_r          (o_r),
    .o_cmd_valid  (cmd_valid),
    .i_cmd_ready  (cmd_ready),
    .o_cmd        (cmd),
    .i_resp_valid (resp_valid),
    .o_resp_ready (resp_ready),
    .i_resp       (resp)
  );

  sram_store u_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_cmd_valid  (cmd_valid),
    .o_cmd_ready  (cmd_ready),
    .i_cmd        (cmd),
    .o_resp_valid (resp_valid),
    .i_resp_ready (resp_ready),
    .o_resp       (resp)
  );

endmodule

/* verification/axi_sram_chk.sv */
`timescale 1ns/100ps

module axi_sram_chk (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  i_aw_valid,
  input logic                  i_aw_ready,
  input axi_sram_pkg::axi_aw_t i_aw,
  input logic                  i_w_valid,
  input logic                  i_w_ready,
  input axi_sram_pkg::axi_w_t  i_w,
  input logic                  i_b_valid,
  input logic                  i_b_ready,
  input axi_sram_pkg::axi_b_t  i_b,
  input logic                  i_ar_valid,
  input logic                  i_ar_ready,
  input axi_sram_pkg::axi_ar_t i_ar,
  input logic                  i_r_valid,
  input logic                  i_r_ready,
  input axi_sram_pkg::axi_r_t  i_r
);
  import axi_sram_pkg::*;

  int assert_fails = 0;

  // Valid and payload hold until the transfer
  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_aw_valid && !i_aw_ready |=> i_aw_valid && $stable(i_aw))
    else begin
      $error("AW dropped or changed while stalled");
      assert_fails++;
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_w_valid && !i_w_ready |=> i_w_valid && $stable(i_w))
    else begin
      $error("W dropped or changed while stalled");
      assert_fails++;
    end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_ar_valid && !i_ar_ready |=> i_ar_valid && $stable(i_ar))
    else begin
      $error("AR dropped or changed while stalled");
      assert_fails++;
    end

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_r_valid && !i_r_ready |=> i_r_valid && $stable(i_r))
    else begin
      $error("R dropped or changed while stalled");
      assert_fails++;
    end

  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_b_valid && !i_b_ready |=> i_b_valid && $stable(i_b))
    else begin
      $error("B dropped or changed while stalled");
      assert_fails++;
    end

  b_okay: assert property (@(posedge clk) disable iff (!rst_n)
    i_b_valid |-> i_b.resp == resp_okay)
    else begin
      $error("bresp is not OKAY");
      assert_fails++;
    end

  r_okay: assert property (@(posedge clk) disable iff (!rst_n)
    i_r_valid |-> i_r.resp == resp_okay)
    else begin
      $error("rresp is not OKAY");
      assert_fails++;
    end

  // One edge into reset the outputs must be quiet
  rst_quiet: assert property (@(posedge clk)
    !rst_n && $past(!rst_n) |-> !i_b_valid && !i_r_valid && !i_w_ready &&
                                !i_aw_ready && !i_ar_ready)
    else begin
      $error("Output active during reset");
      assert_fails++;
    end

endmodule

/* verification/axi_sram_tb.sv */
`timescale 1ns/100ps
`include "axi_sram_macros.svh"

module axi_sram_tb;
  import axi_sram_pkg::*;

  // About 270 beats in all, under 1200 cycles even with stalls and arbitration
  localparam int max_cycles = 3000;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    aw_valid;
  axi_aw_t aw;
  logic    w_valid;
  axi_w_t  w;
  logic    b_ready;
  logic    ar_valid;
  axi_ar_t ar;
  logic    r_ready;
  logic    o_aw_ready;
  logic    o_w_ready;
  logic    o_b_valid;
  axi_b_t  o_b;
  logic    o_ar_ready;
  logic    o_r_valid;
  axi_r_t  o_r;

  logic [`AXI_DATA_W-1:0] shadow [1 << `SRAM_ADDR_W];
  integer seed = 32'h6269_6c9f;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     cycles = 0;
  int     start_errs;

  always #20 clk = ~clk;

  axi_sram_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_aw_valid (aw_valid),
    .o_aw_ready (o_aw_ready),
    .i_aw       (aw),
    .i_w_valid  (w_valid),
    .o_w_ready  (o_w_ready),
    .i_w        (w),
    .o_b_valid  (o_b_valid),
    .i_b_ready  (b_ready),
    .o_b        (o_b),
    .i_ar_valid (ar_valid),
    .o_ar_ready (o_ar_ready),
    .i_ar       (ar),
    .o_r_valid  (o_r_valid),
    .i_r_ready  (r_ready),
    .o_r        (o_r)
  );

  bind axi_sram_top axi_sram_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_aw_valid (i_aw_valid),
    .i_aw_ready (o_aw_ready),
    .i_aw       (i_aw),
    .i_w_valid  (i_w_valid),
    .i_w_ready  (o_w_ready),
    .i_w        (i_w),
    .i_b_valid  (o_b_valid),
    .i_b_ready  (i_b_ready),
    .i_b        (o_b),
    .i_ar_valid (i_ar_valid),
    .i_ar_ready (o_ar_ready),
    .i_ar       (i_ar),
    .i_r_valid  (o_r_valid),
    .i_r_ready  (i_r_ready),
    .i_r        (o_r)
  );

  function int error_total();
    return errors + dut.u_chk.assert_fails;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    if (error_total() == errors_before) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests, name, error_total() - errors_before);
    end
  endtask

  task automatic write_burst(input logic [3:0] id, input logic [11:0] addr, input int beats,
                             input bit rand_strb);
    logic [`SRAM_ADDR_W-1:0] waddr;
    int                      i;
    bit                      done;
    waddr = addr[`AXI_ADDR_W-1:`SRAM_LSB];
    done = 1'b0;
    @(posedge clk);
    #2;
    aw_valid = 1'b1;
    aw = '{id: id, addr: addr, len: 8'(beats - 1), size: 3'd2, burst: 2'b01};
    @(negedge clk);
    while (!o_aw_ready) @(negedge clk);
    @(posedge clk);
    #2;
    aw_valid = 1'b0;
    for (i = 0; i < beats; i++) begin
      w_valid = 1'b1;
      w.data = $random(seed);
      w.strb = rand_strb ? 4'($random(seed)) : 4'hf;
      w.last = (i == beats - 1);
      @(negedge clk);
      while (!o_w_ready) @(negedge clk);
      // Beat lands at the coming edge
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (w.strb[b]) begin
          shadow[waddr][b*8 +: 8] = w.data[b*8 +: 8];
        end
      end
      waddr = waddr + 1'b1;
      @(posedge clk);
      #2;
    end
    w_valid = 1'b0;
    // B ready stalls at random
    while (!done) begin
      b_ready = 1'($random(seed));
      @(negedge clk);
      if (o_b_valid && b_ready) begin
        compare_value("bid", 32'(o_b.id), 32'(id));
        done = 1'b1;
      end
      @(posedge clk);
      #2;
    end
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [11:0] addr, input int beats,
                            input bit stall);
    logic [`SRAM_ADDR_W-1:0] raddr;
    int                      got;
    raddr = addr[`AXI_ADDR_W-1:`SRAM_LSB];
    got = 0;
    @(posedge clk);
    #2;
    ar_valid = 1'b1;
    ar = '{id: id, addr: addr, len: 8'(beats - 1), size: 3'd2, burst: 2'b01};
    @(negedge clk);
    while (!o_ar_ready) @(negedge clk);
    @(posedge clk);
    #2;
    ar_valid = 1'b0;
    while (got < beats) begin
      r_ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge clk);
      if (o_r_valid && r_ready) begin
        compare_value("rdata", o_r.data, shadow[raddr]);
        compare_value("rid", 32'(o_r.id), 32'(id));
        compare_value("rlast", 32'(o_r.last), 32'(got == beats - 1));
        raddr = raddr + 1'b1;
        got++;
      end
      @(posedge clk);
      #2;
    end
    r_ready = 1'b0;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    aw_valid = 1'b0;
    aw = '0;
    w_valid = 1'b0;
    w = '0;
    b_ready = 1'b1;
    ar_valid = 1'b0;
    ar = '0;
    r_ready = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    start_errs = error_total();
    @(negedge clk);
    compare_value("rvalid", 32'(o_r_valid), 32'd0);
    compare_value("bvalid", 32'(o_b_valid), 32'd0);
    compare_value("wready", 32'(o_w_ready), 32'd0);
    compare_value("awready", 32'(o_aw_ready), 32'd0);
    compare_value("arready", 32'(o_ar_ready), 32'd0);
    end_test("reset state", start_errs);

    start_errs = error_total();
    write_burst(4'h1, 12'h000, 1, 1'b0);
    read_burst(4'h2, 12'h000, 1, 1'b0);
    write_burst(4'h3, 12'h040, 4, 1'b0);
    read_burst(4'h4, 12'h040, 4, 1'b0);
    write_burst(4'h5, 12'h080, 16, 1'b0);
    read_burst(4'h6, 12'h080, 16, 1'b0);
    end_test("full strobe bursts", start_errs);

    start_errs = error_total();
    write_burst(4'h7, 12'h100, 4, 1'b0);
    write_burst(4'h8, 12'h100, 4, 1'b1);
    read_burst(4'h9, 12'h100, 4, 1'b0);
    end_test("partial strobes", start_errs);

    start_errs = error_total();
    write_burst(4'h5, 12'h200, 8, 1'b0);
    read_burst(4'ha, 12'h200, 8, 1'b0);
    end_test("ids and rlast", start_errs);

    start_errs = error_total();
    write_burst(4'hb, 12'h400, 64, 1'b0);
    read_burst(4'hd, 12'h400, 64, 1'b1);
    end_test("rready stalls", start_errs);

    // Write and read run side by side on disjoint regions, a second of each queues behind
    start_errs = error_total();
    fork
      write_burst(4'h3, 12'h800, 16, 1'b1);
      read_burst(4'hc, 12'h080, 16, 1'b1);
      begin
        repeat (2) @(posedge clk);
        write_burst(4'h6, 12'hc00, 8, 1'b1);
      end
      begin
        repeat (2) @(posedge clk);
        read_burst(4'hf, 12'h040, 4, 1'b0);
      end
    join
    read_burst(4'he, 12'h800, 16, 1'b0);
    read_burst(4'h2, 12'hc00, 8, 1'b0);
    end_test("concurrent traffic", start_errs);

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, error_total());
    if (error_total() == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+include
logic/axi_sram_pkg.sv
logic/axi_sram_wr.sv
logic/axi_sram_rd.sv
logic/axi_sram_bridge.sv
logic/sram_store.sv
logic/axi_sram_top.sv
verification/axi_sram_chk.sv
verification/axi_sram_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/100ps -f list.f \
  --top-module axi_sram_tb -Mdir obj_dir -o axi_sram_sim &&
{ ./obj_dir/axi_sram_sim +verilator+error+limit+1000 > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q "Finished with no errors" sim.log &&
! grep -q "Finished with errors" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
